/* logic/adder_params.svh */
`ifndef ADDER_PARAMS_SVH
`define ADDER_PARAMS_SVH
`default_nettype none

// datapath width in bits
`define ADDER_WIDTH 32
// prefix net select: 2 sklansky, 1 brent-kung, 0 serial
`define ADDER_SPEED 2

`define WB_ADR_W 3 // word address bits

// register map, word offsets
`define REG_OPA    `WB_ADR_W'(0)
`define REG_OPB    `WB_ADR_W'(1)
`define REG_CTRL   `WB_ADR_W'(2)
`define REG_RESULT `WB_ADR_W'(3)
`define REG_STATUS `WB_ADR_W'(4)

`default_nettype wire
`endif

/* logic/adderPkg.sv */
`include "adder_params.svh"
`default_nettype none

package adderPkg;

	// arithmetic opcodes, ctrl bits 1:0
	typedef enum logic [1:0] {
		ADD  = 2'd0,
		SUB  = 2'd1,
		ADDC = 2'd2, // add with stored carry
		SUBB = 2'd3  // subtract with stored borrow
	} opCodeE;

	typedef struct packed {
		logic carry;    // no-borrow on subtract
		logic zero;
		logic negative;
		logic overflow; // signed overflow
	} flagsT;

	// wishbone classic, master side
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [`WB_ADR_W-1:0]    adr;
		logic [`ADDER_WIDTH-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic                    ack;
		logic [`ADDER_WIDTH-1:0] dat; // valid with ack
	} wbRspT;

	// regs -> arithmetic stage
	typedef struct packed {
		logic                    go; // one cycle pulse
		opCodeE                  op;
		logic [`ADDER_WIDTH-1:0] a;
		logic [`ADDER_WIDTH-1:0] b;
	} aluReqT;

	typedef struct packed {
		logic                    valid; // cycle after go
		logic [`ADDER_WIDTH-1:0] result;
		flagsT                   flags;
	} aluRspT;

endpackage

`default_nettype wire

/* logic/prefixAndOr.sv */
`timescale 1ns/10ps
`default_nettype none

module prefixAndOr #(
	parameter int width = 8, // bits
	parameter int speed = 2  // 2 sklansky, 1 brent-kung, else serial
) (
	input  logic [width-1:0] gi, // bit generate
	input  logic [width-1:0] pi, // bit propagate
	output logic [width-1:0] go, // group generate, bit 0 up to i
	output logic [width-1:0] po  // group propagate
);

	localparam int n = width;
	localparam int m = $clog2(width); // log depth

	if (speed == 2) begin : sklansky
		// level 0 is the input row
		logic [m:0][n-1:0] gT, pT;

		assign gT[0] = gi;
		assign pT[0] = pi;

		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar j = 0; j < n; j++) begin : bits
				if (((j >> (l - 1)) & 1) == 0) begin : white
					// lower half of block, nothing to merge
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end else begin : black
					// merge with top bit of lower half
					localparam int src = ((j >> l) << l) + 2**(l-1) - 1;
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end
			end
		end

		assign go = gT[m];
		assign po = pT[m];
	end else if (speed == 1) begin : brentKung
		// up-sweep levels 1..m, down-sweep m+1..2m-1
		localparam int last = (m > 0) ? 2*m - 1 : 0;
		logic [last:0][n-1:0] gT, pT;

		assign gT[0] = gi;
		assign pT[0] = pi;

		for (genvar l = 1; l <= last; l++) begin : levels
			localparam int d = (l <= m) ? l : 2*m - l; // span exponent
			for (genvar j = 0; j < n; j++) begin : bits
				// up-sweep hits block tops, down-sweep fills mid points
				localparam bit isBlack = (l <= m) ?
					((j + 1) % (2**d) == 0) :
					((j >= 2**d) && ((j + 1) % (2**d) == 2**(d-1)));
				if (isBlack) begin : black
					localparam int src = j - 2**(d-1);
					assign gT[l][j] = gT[l-1][j] | (pT[l-1][j] & gT[l-1][src]);
					assign pT[l][j] = pT[l-1][j] & pT[l-1][src];
				end else begin : white
					assign gT[l][j] = gT[l-1][j];
					assign pT[l][j] = pT[l-1][j];
				end
			end
		end

		assign go = gT[last];
		assign po = pT[last];
	end else begin : serial
		// plain ripple, smallest area
		logic [n-1:0] gT, pT;

		assign gT[0] = gi[0];
		assign pT[0] = pi[0];

		for (genvar j = 1; j < n; j++) begin : bits
			assign gT[j] = gi[j] | (pi[j] & gT[j-1]);
			assign pT[j] = pi[j] & pT[j-1];
		end

		assign go = gT;
		assign po = pT;
	end

endmodule

`default_nettype wire

/* logic/addCfast.sv */
`timescale 1ns/10ps
`default_nettype none

// {co, s} = a + b + ci
module addCfast #(
	parameter int width = 8, // operand bits
	parameter int speed = 2  // prefix structure select
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             ci, // late arriving carry in
	output logic [width-1:0] s,
	output logic             co
);

	logic [width-1:0] gBit, pBit; // per bit gen/prop
	logic [width-1:0] hSum;       // half sum
	logic [width-1:0] gGrp, pGrp; // prefix outputs
	logic [width-1:0] gCin;       // group gen incl. carry in

	assign gBit = a & b;
	assign pBit = a | b;
	assign hSum = a ^ b;

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix0 (
		.gi(gBit),
		.pi(pBit),
		.go(gGrp),
		.po(pGrp)
	);

	// one extra or-and row, ci skips the prefix tree
	assign gCin = gGrp | (pGrp & {width{ci}});

	assign s  = hSum ^ {gCin[width-2:0], ci}; // carry into bit i from i-1
	assign co = gCin[width-1];

endmodule

`default_nettype wire

/* logic/addSubUnit.sv */
`timescale 1ns/10ps
`include "adder_params.svh"
`default_nettype none

module addSubUnit (
	input  logic             clk,
	input  logic             rstN,
	input  adderPkg::aluReqT req,
	input  logic             storedCarry, // carry flag of last op
	output adderPkg::aluRspT rsp
);

	localparam int W = `ADDER_WIDTH;

	logic [W-1:0]    bOp;      // b after optional inversion
	logic [W-1:0]    sum;
	logic            cIn;
	logic            cOut;
	logic            subMode;
	adderPkg::flagsT flagsNext;

	always_comb begin
		subMode = (req.op == adderPkg::SUB) || (req.op == adderPkg::SUBB);
		bOp     = subMode ? ~req.b : req.b; // a - b = a + ~b + 1
		case (req.op)
			adderPkg::ADD: cIn = 1'b0;
			adderPkg::SUB: cIn = 1'b1;
			default:       cIn = storedCarry; // chained ops, addc / subb
		endcase
	end

	addCfast #(
		.width(W),
		.speed(`ADDER_SPEED)
	) add0 (
		.a (req.a),
		.b (bOp),
		.ci(cIn),
		.s (sum),
		.co(cOut)
	);

	always_comb begin
		flagsNext.carry    = cOut; // high means no borrow on sub
		flagsNext.zero     = (sum == '0);
		flagsNext.negative = sum[W-1];
		// same operand signs, different result sign
		flagsNext.overflow = (req.a[W-1] == bOp[W-1]) && (sum[W-1] != req.a[W-1]);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rsp <= '0;
		end else begin
			rsp.valid <= req.go; // single cycle op
			if (req.go) begin
				rsp.result <= sum;
				rsp.flags  <= flagsNext;
			end
		end
	end

	// prefix adder against plain addition, lands the cycle after go
	assert property (@(posedge clk) disable iff (!rstN)
		req.go |=> rsp.valid &&
			{rsp.flags.carry, rsp.result} == $past({1'b0, req.a} + {1'b0, bOp} + 33'(cIn)));

endmodule

`default_nettype wire

/* logic/wbAdderRegs.sv */
`timescale 1ns/10ps
`include "adder_params.svh"
`default_nettype none

module wbAdderRegs (
	input  logic             clk,
	input  logic             rstN,
	input  adderPkg::wbReqT  wbReq,
	output adderPkg::wbRspT  wbRsp,
	output adderPkg::aluReqT aluReq,
	input  adderPkg::aluRspT aluRsp,
	output logic             storedCarry
);

	localparam int W         = `ADDER_WIDTH;
	localparam int CTRL_GO   = 4; // ctrl go bit
	localparam int STAT_BUSY = 8; // status busy bit

	logic [W-1:0]     opA, opB;
	logic [W-1:0]     resultQ;
	logic [W-1:0]     rdData, rdQ;
	adderPkg::opCodeE opQ;
	adderPkg::flagsT  flagsQ;
	logic             ackQ, goQ, busyQ;
	logic             access;  // new cycle, ack not yet given
	logic             wrEn;
	logic             ctrlGo;

	assign access = wbReq.cyc && wbReq.stb && !ackQ;
	assign wrEn   = access && wbReq.we; // commits on the ack edge
	assign ctrlGo = wrEn && (wbReq.adr == `REG_CTRL) && wbReq.dat[CTRL_GO];

	always_comb begin
		rdData = '0;
		case (wbReq.adr)
			`REG_OPA:    rdData = opA;
			`REG_OPB:    rdData = opB;
			`REG_CTRL:   rdData[1:0] = opQ; // go reads back 0
			`REG_RESULT: rdData = resultQ;
			`REG_STATUS: begin
				rdData[3:0]       = flagsQ;
				rdData[STAT_BUSY] = busyQ;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ackQ    <= 1'b0;
			rdQ     <= '0;
			opA     <= '0;
			opB     <= '0;
			opQ     <= adderPkg::ADD;
			goQ     <= 1'b0;
			busyQ   <= 1'b0;
			resultQ <= '0;
			flagsQ  <= '0;
		end else begin
			ackQ <= access; // one cycle ack, no wait states
			goQ  <= ctrlGo;
			if (access && !wbReq.we)
				rdQ <= rdData;
			if (wrEn && wbReq.adr == `REG_OPA)
				opA <= wbReq.dat;
			if (wrEn && wbReq.adr == `REG_OPB)
				opB <= wbReq.dat;
			if (wrEn && wbReq.adr == `REG_CTRL)
				opQ <= adderPkg::opCodeE'(wbReq.dat[1:0]);
			// new go wins over completion of the previous op
			if (ctrlGo)
				busyQ <= 1'b1;
			else if (aluRsp.valid)
				busyQ <= 1'b0;
			if (aluRsp.valid) begin
				resultQ <= aluRsp.result;
				flagsQ  <= aluRsp.flags;
			end
		end
	end

	assign wbRsp       = '{ack: ackQ, dat: rdQ};
	assign aluReq      = '{go: goQ, op: opQ, a: opA, b: opB};
	assign storedCarry = flagsQ.carry; // feeds addc / subb

	// master keeps request and address up until it sees ack
	assert property (@(posedge clk) disable iff (!rstN)
		wbReq.cyc && wbReq.stb && !wbRsp.ack |=>
			wbReq.cyc && wbReq.stb && $stable(wbReq.adr));

endmodule

`default_nettype wire

/* logic/adderTop.sv */
`timescale 1ns/10ps
`default_nettype none

module adderTop (
	input  logic            clk,
	input  logic            rstN,
	input  adderPkg::wbReqT wbReq, // host bus
	output adderPkg::wbRspT wbRsp
);

	adderPkg::aluReqT aluReq; // operands, op and go pulse
	adderPkg::aluRspT aluRsp; // result and flags
	logic             storedCarry;

	// bus slave and register file
	wbAdderRegs regs0 (
		.clk        (clk),
		.rstN       (rstN),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.aluReq     (aluReq),
		.aluRsp     (aluRsp),
		.storedCarry(storedCarry)
	);

	// single cycle add / sub stage
	addSubUnit alu0 (
		.clk        (clk),
		.rstN       (rstN),
		.req        (aluReq),
		.storedCarry(storedCarry),
		.rsp        (aluRsp)
	);

endmodule

`default_nettype wire

/* verif/adderTb.sv */
`timescale 1ns/10ps
`include "adder_params.svh"
`default_nettype none

module adderTb;

	localparam int ackTimeout  = 16; // cycles per bus access
	localparam int busyTimeout = 32; // status polls
	localparam int goBit       = 4;  // ctrl go
	localparam int busyBit     = 8;  // status busy

	typedef struct packed {
		logic [1:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [3:0]  fl; // carry, zero, negative, overflow
	} vecT;

	logic            clk;
	logic            rstN;
	adderPkg::wbReqT wbReq;
	adderPkg::wbRspT wbRsp;
	vecT             vecs [0:39]; // stimulus table
	int              nVec;
	int              errors;
	int              checks;
	int              seed;

	adderTop dut0 (
		.clk  (clk),
		.rstN (rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// expected result and flags from plain 33 bit arithmetic
	function automatic logic [35:0] refAlu(input logic [1:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic cPrev);
		logic        isSub;
		logic        cin;   // carry in, no-borrow on subtract
		logic [32:0] wide;  // unsigned, bit 32 carry or borrow out
		logic [32:0] exact; // sign extended true result
		logic        carry;
		logic        ovf;
		isSub = (op == adderPkg::SUB) || (op == adderPkg::SUBB);
		cin   = (op == adderPkg::ADD) ? 1'b0 : (op == adderPkg::SUB) ? 1'b1 : cPrev;
		if (isSub) begin
			wide  = {1'b0, a} - {1'b0, b} - {32'd0, !cin};
			exact = {a[31], a} - {b[31], b} - {32'd0, !cin};
			carry = !wide[32]; // a covers b plus borrow
		end else begin
			wide  = {1'b0, a} + {1'b0, b} + {32'd0, cin};
			exact = {a[31], a} + {b[31], b} + {32'd0, cin};
			carry = wide[32];
		end
		ovf = exact[32] != exact[31]; // signed result does not fit 32 bits
		return {wide[31:0], carry, wide[31:0] == 32'd0, wide[31], ovf};
	endfunction

	task automatic addVec(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] res, input logic [3:0] fl);
		vecs[nVec] = '{op, a, b, res, fl};
		nVec++;
	endtask

	task automatic fillTable();
		logic [35:0] expV;
		logic [31:0] rnd;
		logic [31:0] a;
		logic [31:0] b;
		logic        carryModel; // carry flag the unit keeps between ops
		addVec(adderPkg::ADD, 32'h00000001, 32'h00000002, 32'h00000003, 4'b0000);
		addVec(adderPkg::ADD, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 4'b1100);
		addVec(adderPkg::ADD, 32'h7FFFFFFF, 32'h00000001, 32'h80000000, 4'b0011);
		addVec(adderPkg::ADD, 32'h80000000, 32'h80000000, 32'h00000000, 4'b1101);
		addVec(adderPkg::SUB, 32'h00000005, 32'h00000003, 32'h00000002, 4'b1000);
		addVec(adderPkg::SUB, 32'h00000003, 32'h00000005, 32'hFFFFFFFE, 4'b0010);
		addVec(adderPkg::SUB, 32'h80000000, 32'h00000001, 32'h7FFFFFFF, 4'b1001);
		addVec(adderPkg::SUB, 32'h00000007, 32'h00000007, 32'h00000000, 4'b1100);
		// 64 bit pairs, low word then high word
		addVec(adderPkg::ADD, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 4'b1100);
		addVec(adderPkg::ADDC, 32'hFFFFFFFF, 32'h00000000, 32'h00000000, 4'b1100); // full ripple
		addVec(adderPkg::ADD, 32'h9ABCDEF0, 32'h87654321, 32'h22222211, 4'b1001);
		addVec(adderPkg::ADDC, 32'h12345678, 32'h0FEDCBA9, 32'h22222222, 4'b0000);
		addVec(adderPkg::SUB, 32'h00000000, 32'h00000001, 32'hFFFFFFFF, 4'b0010);
		addVec(adderPkg::SUBB, 32'h00000001, 32'h00000000, 32'h00000000, 4'b1100);
		addVec(adderPkg::SUB, 32'h00000000, 32'h00000001, 32'hFFFFFFFF, 4'b0010);
		addVec(adderPkg::SUBB, 32'h00000000, 32'h00000000, 32'hFFFFFFFF, 4'b0010); // borrow ripple
		carryModel = vecs[nVec-1].fl[3];
		for (int i = 0; i < 20; i++) begin
			a          = $random(seed);
			b          = $random(seed);
			rnd        = $random(seed);
			expV       = refAlu(rnd[1:0], a, b, carryModel);
			carryModel = expV[3];
			addVec(rnd[1:0], a, b, expV[35:4], expV[3:0]);
		end
	endtask

	// request stays up after ack, next access takes over on the ack clearing edge
	task automatic wbWrite(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] dat);
		int waited;
		@(posedge clk);
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		waited = 0;
		do begin
			@(negedge clk); // ack stable here
			waited++;
		end while (!wbRsp.ack && waited < ackTimeout);
		if (!wbRsp.ack) begin
			$display("ERROR at %0t ns: write to register %0d was never acknowledged", $time, adr);
			errors++;
		end
	endtask

	task automatic wbRead(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] dat);
		int waited;
		dat = '0;
		@(posedge clk);
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wbRsp.ack && waited < ackTimeout);
		if (wbRsp.ack) begin
			dat = wbRsp.dat; // valid while ack high
		end else begin
			$display("ERROR at %0t ns: read of register %0d was never acknowledged", $time, adr);
			errors++;
		end
	endtask

	task automatic busIdle();
		@(posedge clk);
		wbReq <= '0;
	endtask

	task automatic pollBusy();
		logic [31:0] st;
		int          polls;
		wbRead(`REG_STATUS, st); // back to back with the go write
		checkEq({31'd0, st[busyBit]}, 32'd1, "busy right after go");
		polls = 0;
		while (st[busyBit] && polls < busyTimeout) begin
			wbRead(`REG_STATUS, st);
			polls++;
		end
		if (st[busyBit]) begin
			$display("ERROR at %0t ns: busy bit never cleared after go", $time);
			errors++;
		end
	endtask

	task automatic runVec(input int i);
		logic [31:0] got;
		wbWrite(`REG_OPA, vecs[i].a);
		wbWrite(`REG_OPB, vecs[i].b);
		wbWrite(`REG_CTRL, (32'd1 << goBit) | {30'd0, vecs[i].op});
		pollBusy();
		wbRead(`REG_RESULT, got);
		checkEq(got, vecs[i].res, $sformatf("entry %0d op %0d result", i, vecs[i].op));
		wbRead(`REG_STATUS, got);
		checkEq(got, {28'd0, vecs[i].fl}, $sformatf("entry %0d op %0d status", i, vecs[i].op));
		busIdle();
	endtask

	initial begin
		logic [31:0] got;
		wbReq  = '0;
		rstN   = 1'b0;
		nVec   = 0;
		errors = 0;
		checks = 0;
		seed   = 26478;
		fillTable();
		repeat (16) @(posedge clk);
		rstN <= 1'b1;

		wbRead(`REG_RESULT, got);
		checkEq(got, 32'd0, "result after reset");
		wbRead(`REG_STATUS, got);
		checkEq(got, 32'd0, "status after reset"); // busy included
		busIdle();

		for (int i = 0; i < nVec; i++)
			runVec(i);

		// operand readback, result is read only
		wbWrite(`REG_OPA, 32'hA5A50F0F);
		wbWrite(`REG_OPB, 32'h3C3CC3C3);
		wbWrite(`REG_RESULT, 32'hDEADBEEF);
		wbRead(`REG_OPA, got);
		checkEq(got, 32'hA5A50F0F, "opA readback");
		wbRead(`REG_OPB, got);
		checkEq(got, 32'h3C3CC3C3, "opB readback");
		wbRead(`REG_RESULT, got);
		checkEq(got, vecs[nVec-1].res, "result after ignored write");
		busIdle();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/adderPkg.sv
logic/prefixAndOr.sv
logic/addCfast.sv
logic/addSubUnit.sv
logic/wbAdderRegs.sv
logic/adderTop.sv
verif/adderTb.sv
